// ==== filelist.f ====
+incdir+verilog
+incdir+sim
verilog/dma_seq_pkg.sv
verilog/maria_list_pkg.sv
verilog/halt_ctrl.sv
verilog/dma_sequencer.sv
verilog/pointer_file.sv
verilog/line_out.sv
verilog/maria_dma.sv
sim/tb_maria_dma.sv

// ==== Makefile ====
# Verilator build and run for the display-list DMA testbench

SRCS := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv sim/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_maria_dma: $(SRCS) filelist.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_maria_dma -f filelist.f -Mdir obj_dir

# The log decides pass or fail
run: obj_dir/Vtb_maria_dma
	-./obj_dir/Vtb_maria_dma > sim.log 2>&1
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_dl_model.svh ====
//////////////////////////////////////////////////
// Testbench display-list builder and model
// LFSR, random lists, expected reads and events
//////////////////////////////////////////////////

`ifndef TB_DL_MODEL_SVH
`define TB_DL_MODEL_SVH

localparam int          NUM_ZONES = 4;
localparam logic [15:0] DLL_BASE  = 16'h1000;
localparam logic [15:0] LIST_BASE = 16'h2000; // 64 bytes of headers per zone

logic [7:0]  mem [0:65535];
logic [31:0] lfsr_state = 32'hf8e5afa9;
int unsigned exp_addr[$]; // Distinct bus addresses in read order
logic [31:0] exp_evt[$];  // Line-RAM and DLI events
int          total_lines;

// Model of the engine's zone state
logic [15:0] m_zptr;
logic [15:0] m_dlbase;
logic [3:0]  m_off;
logic        m_h16;
logic        m_h8;
logic        m_dli;
logic        m_wm = 1'b0; // Survives short headers and frames

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

// Kind 1 hpos, 2 graphics byte, 3 DLI
function automatic logic [31:0] make_event(input logic [7:0] kind, input logic [2:0] pal,
	input logic wm, input logic [7:0] data);
	return {kind, 5'b0, pal, 7'b0, wm, data};
endfunction

function automatic logic is_hole(input logic [15:0] a);
	return a[15] && ((m_h16 && a[12]) || (m_h8 && a[11]));
endfunction

task automatic fill_memory();
	for (int a = 0; a < 65536; a++)
		mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h3c; // Both address bytes matter
endtask

task automatic build_display_list();
	logic [15:0] p;
	logic [15:0] d;
	logic [3:0]  off;
	logic [7:0]  b0;
	logic [7:0]  hi;
	logic [7:0]  lo;
	logic [7:0]  pw;
	logic [7:0]  mode;
	logic [1:0]  r;
	int          nhdr;
	total_lines = 0;
	for (int z = 0; z < NUM_ZONES; z++) begin
		d     = DLL_BASE + 16'(3 * z);
		p     = LIST_BASE + 16'(64 * z);
		off   = 4'(rand_bits(2) % 3);
		b0    = {4'b0, off};
		b0[7] = rand_bits(1) == 1;  // DLI half the time
		b0[6] = rand_bits(2) == 0;  // holey16
		b0[5] = rand_bits(2) == 0;  // holey8
		mem[d]          = b0;
		mem[d + 16'd1]  = p[15:8];
		mem[d + 16'd2]  = p[7:0];
		total_lines    += off + 1;
		nhdr = 1 + int'(rand_bits(2));
		for (int h = 0; h < nhdr; h++) begin
			r = 2'(rand_bits(2));
			if (r == 0)
				hi = 8'h87; // Crosses A11
			else if (r == 1)
				hi = 8'h8F; // Crosses A12
			else
				hi = 8'h40 + 8'(rand_bits(3));
			lo = hi[7] ? 8'hFC + 8'(rand_bits(2)) : 8'(rand_bits(8));
			pw[7:5] = 3'(rand_bits(3));
			pw[4:0] = 5'd28 + 5'(rand_bits(2)); // 1 to 4 bytes
			mem[p]          = lo;
			mem[p + 16'd2]  = hi;
			if (rand_bits(1) == 1) begin
				mode    = 8'h40;              // Long marker, width zero
				mode[7] = rand_bits(1) == 1;  // Write mode
				mode[5] = rand_bits(1) == 1;  // Indirect, ignored
				mem[p + 16'd1] = mode;
				mem[p + 16'd3] = pw;
				mem[p + 16'd4] = 8'(rand_bits(8));
				p = p + 16'd5;
			end else begin
				mem[p + 16'd1] = pw;
				mem[p + 16'd3] = 8'(rand_bits(8));
				p = p + 16'd4;
			end
		end
		mem[p] = 8'(rand_bits(8));
		mode    = 8'h00;
		mode[7] = rand_bits(1) == 1; // Masked bits of the end marker
		mode[5] = rand_bits(1) == 1;
		mem[p + 16'd1] = mode;
	end
	// Spare entry, fetched after the last zone
	d = DLL_BASE + 16'(3 * NUM_ZONES);
	mem[d]         = 8'h00;
	mem[d + 16'd1] = 8'h2F;
	mem[d + 16'd2] = 8'h00;
endtask

task automatic model_read_dll();
	logic [7:0] b0;
	exp_addr.push_back(m_zptr);
	exp_addr.push_back(m_zptr + 16'd1);
	exp_addr.push_back(m_zptr + 16'd2);
	b0       = mem[m_zptr];
	m_dli    = b0[7];
	m_h16    = b0[6];
	m_h8     = b0[5];
	m_off    = b0[3:0];
	m_dlbase = {mem[m_zptr + 16'd1], mem[m_zptr + 16'd2]};
	m_zptr   = m_zptr + 16'd3;
endtask

task automatic model_zone(input logic [15:0] zp);
	m_zptr = zp;
	model_read_dll();
endtask

task automatic model_line();
	logic [15:0] p;
	logic [15:0] g;
	logic [15:0] a;
	logic [7:0]  b1;
	logic [7:0]  pw;
	logic [7:0]  hpos;
	logic        done;
	int          n;
	p    = m_dlbase;
	done = 1'b0;
	while (!done) begin
		exp_addr.push_back(p);
		exp_addr.push_back(p + 16'd1);
		b1 = mem[p + 16'd1];
		if ((b1 & 8'h5F) == 8'h00) begin
			done = 1'b1;
		end else begin
			exp_addr.push_back(p + 16'd2);
			g = {mem[p + 16'd2], mem[p]};
			if (b1[6] && b1[4:0] == 5'd0) begin // Five-byte header
				m_wm = b1[7];
				pw   = mem[p + 16'd3];
				hpos = mem[p + 16'd4];
				exp_addr.push_back(p + 16'd3);
				exp_addr.push_back(p + 16'd4);
				p = p + 16'd5;
			end else begin
				pw   = b1;
				hpos = mem[p + 16'd3];
				exp_addr.push_back(p + 16'd3);
				p = p + 16'd4;
			end
			exp_evt.push_back(make_event(8'd1, pw[7:5], m_wm, hpos));
			n = 32 - int'(pw[4:0]);
			for (int i = 0; i < n; i++) begin
				a = g + 16'(i) + {4'b0, m_off, 8'h00};
				exp_addr.push_back(a); // Hole byte is read but not written
				if (is_hole(a))
					break;
				exp_evt.push_back(make_event(8'd2, pw[7:5], m_wm, mem[a]));
			end
		end
	end
	if (m_off == 4'd0) begin
		if (m_dli)
			exp_evt.push_back(make_event(8'd3, 3'd0, 1'b0, 8'd0));
		model_read_dll();
	end else begin
		m_off = m_off - 4'd1;
	end
endtask

`endif

// ==== sim/tb_maria_dma.sv ====
//////////////////////////////////////////////////
// Display-list DMA testbench
// Random lists against a reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_maria_dma;

	localparam int     NUM_FRAMES = 2;
	localparam int     MAX_LINES  = 12;  // 4 zones of up to 3 lines
	localparam int     MAX_HDRS   = 5;   // Headers plus end marker
	localparam int     MARGIN     = 2000;
	localparam longint WATCHDOG_NS =
		longint'(NUM_FRAMES * MAX_LINES * MAX_HDRS * 35 * 3 + MARGIN) * 100;

	logic        clk_sys = 1'b0;
	logic        HALTRST;
	logic        vbe;
	logic        hbs;
	logic        vblank;
	logic        dma_en;
	logic [15:0] zp;
	logic [7:0]  d_in;
	logic        halt;
	logic [15:0] ab;
	logic        aben;
	logic [7:0]  lr_data;
	logic        latch_byte;
	logic        latch_hpos;
	logic [2:0]  pal;
	logic        wm;
	logic        nmi_n;

	// Monitor history
	logic        prev_aben;
	logic [15:0] prev_ab;
	logic        prev_nmi_n;
	int          nmi_len;

	`include "tb_dl_model.svh"

	maria_dma UUT (
		.clk_sys    (clk_sys),
		.HALTRST    (HALTRST),
		.vbe        (vbe),
		.hbs        (hbs),
		.vblank     (vblank),
		.dma_en     (dma_en),
		.zp         (zp),
		.d_in       (d_in),
		.halt       (halt),
		.ab         (ab),
		.aben       (aben),
		.lr_data    (lr_data),
		.latch_byte (latch_byte),
		.latch_hpos (latch_hpos),
		.pal        (pal),
		.wm         (wm),
		.nmi_n      (nmi_n)
	);

	always #50 clk_sys = ~clk_sys; // 100 ns

	// Memory answers ab within the slot
	always @(posedge clk_sys) begin
		#10;
		d_in = mem[ab];
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp) begin
			$display("FAIL %0t ns: %s, got %h expected %h", $time, what, act, exp);
			stop_with_failure("value mismatch");
		end
	endtask

	task automatic expect_addr(input logic [15:0] a);
		if (exp_addr.size() == 0)
			stop_with_failure("memory read with no read expected");
		else
			check_eq(a, exp_addr.pop_front(), "read address");
	endtask

	task automatic expect_event(input logic [31:0] e);
		if (exp_evt.size() == 0)
			stop_with_failure("line-RAM or DLI event with none expected");
		else
			check_eq(e, exp_evt.pop_front(), "event kind/pal/wm/data");
	endtask

	// Outputs settled mid-cycle
	always @(negedge clk_sys) begin
		if (HALTRST) begin
			prev_aben  = 1'b0;
			prev_ab    = '0;
			prev_nmi_n = 1'b1;
			nmi_len    = 0;
		end else begin
			if (aben && !halt)
				stop_with_failure("address bus enabled outside a DMA");
			if (aben && !(prev_aben && ab == prev_ab))
				expect_addr(ab); // One entry per slot
			if (latch_hpos)
				expect_event(make_event(8'd1, pal, wm, lr_data));
			if (latch_byte)
				expect_event(make_event(8'd2, pal, wm, lr_data));
			if (!nmi_n) begin
				if (prev_nmi_n)
					expect_event(make_event(8'd3, 3'd0, 1'b0, 8'd0));
				nmi_len++;
			end else if (!prev_nmi_n) begin
				check_eq(nmi_len, 4, "nmi_n low cycles");
				nmi_len = 0;
			end
			prev_aben  = aben;
			prev_ab    = ab;
			prev_nmi_n = nmi_n;
		end
	end

	// Accepted trigger then a dropped one while busy and a wait for done
	task automatic run_dma(input logic zone);
		@(posedge clk_sys);
		#10;
		check_eq(halt, 1'b0, "halt low before trigger");
		if (zone)
			vbe = 1'b1;
		else
			hbs = 1'b1;
		@(posedge clk_sys);
		#10;
		vbe = 1'b0;
		hbs = 1'b0;
		check_eq(halt, 1'b1, "halt one cycle after trigger");
		repeat (2) @(posedge clk_sys);
		#10;
		check_eq(halt, 1'b1, "halt held during DMA");
		vbe = 1'b1; // Ignored while busy
		@(posedge clk_sys);
		#10;
		vbe = 1'b0;
		while (halt) begin
			@(posedge clk_sys);
			#10;
		end
		repeat (3) @(posedge clk_sys);
		#10;
		check_eq(exp_addr.size(), 0, "reads still expected after DMA");
		check_eq(exp_evt.size(), 0, "events still expected after DMA");
	endtask

	// Trigger that must not start anything
	task automatic blocked_trigger(input logic zone);
		@(posedge clk_sys);
		#10;
		if (zone)
			vbe = 1'b1;
		else
			hbs = 1'b1;
		@(posedge clk_sys);
		#10;
		vbe = 1'b0;
		hbs = 1'b0;
		repeat (4) begin
			check_eq(halt, 1'b0, "halt after blocked trigger");
			check_eq(aben, 1'b0, "aben after blocked trigger");
			@(posedge clk_sys);
			#10;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("timeout, the DMA runs did not finish in time");
	end

	initial begin
		HALTRST = 1'b1;
		vbe     = 1'b0;
		hbs     = 1'b0;
		vblank  = 1'b1;
		dma_en  = 1'b1;
		zp      = DLL_BASE;
		d_in    = 8'h00;
		fill_memory();
		build_display_list();
		repeat (3) @(posedge clk_sys);
		#10;
		HALTRST = 1'b0;
		check_eq(halt, 1'b0, "halt after reset");
		check_eq(aben, 1'b0, "aben after reset");
		check_eq(latch_byte, 1'b0, "latch_byte after reset");
		check_eq(latch_hpos, 1'b0, "latch_hpos after reset");
		check_eq(nmi_n, 1'b1, "nmi_n after reset");
		check_eq(pal, 3'd0, "pal after reset");
		check_eq(wm, 1'b0, "wm after reset");

		dma_en = 1'b0;
		blocked_trigger(1'b1); // Disabled
		dma_en = 1'b1;
		blocked_trigger(1'b0); // hbs in vblank

		for (int f = 0; f < NUM_FRAMES; f++) begin
			vblank = 1'b1;
			model_zone(DLL_BASE);
			run_dma(1'b1);
			vblank = 1'b0;
			for (int l = 0; l < total_lines; l++) begin
				model_line();
				run_dma(1'b0);
			end
			dma_en = 1'b0;
			blocked_trigger(1'b0); // Line start while disabled
			dma_en = 1'b1;
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== verilog/maria_dma.sv ====
//////////////////////////////////////////////////
// Display-list DMA engine top level
// Start control, sequencer, pointers, line output
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "maria_consts.svh"

module maria_dma (
	input  logic                     clk_sys,
	input  logic                     HALTRST,
	input  logic                     vbe,     // Vblank end pulse
	input  logic                     hbs,     // Hblank start pulse
	input  logic                     vblank,
	input  logic                     dma_en,
	input  logic [`MARIA_ADDR_W-1:0] zp,      // DLL base
	input  logic [7:0]               d_in,
	output logic                     halt,
	output logic [`MARIA_ADDR_W-1:0] ab,
	output logic                     aben,
	output logic [7:0]               lr_data,
	output logic                     latch_byte,
	output logic                     latch_hpos,
	output logic [`MARIA_PAL_W-1:0]  pal,
	output logic                     wm,
	output logic                     nmi_n
);

	dma_seq_pkg::dma_kind_e kind;
	dma_seq_pkg::dma_step_e step;
	logic                   start;
	logic                   dma_done;
	logic                   sample;
	logic                   next_byte;
	logic                   pal_load;
	logic                   wm_load;
	logic                   hpos_load;
	logic                   gfx_load;
	logic                   dli_fire;
	logic                   offset_zero;
	logic                   width_last;
	logic                   in_hole;
	logic                   dli_flag;

	halt_ctrl u_halt_ctrl (
		.clk_sys  (clk_sys),
		.HALTRST  (HALTRST),
		.vbe      (vbe),
		.hbs      (hbs),
		.vblank   (vblank),
		.dma_en   (dma_en),
		.dma_done (dma_done),
		.start    (start),
		.kind     (kind),
		.halt     (halt)
	);

	dma_sequencer u_dma_sequencer (
		.clk_sys     (clk_sys),
		.HALTRST     (HALTRST),
		.start       (start),
		.kind        (kind),
		.d_in        (d_in),
		.offset_zero (offset_zero),
		.width_last  (width_last),
		.in_hole     (in_hole),
		.dli_flag    (dli_flag),
		.step        (step),
		.sample      (sample),
		.next_byte   (next_byte),
		.pal_load    (pal_load),
		.wm_load     (wm_load),
		.hpos_load   (hpos_load),
		.gfx_load    (gfx_load),
		.dli_fire    (dli_fire),
		.dma_done    (dma_done)
	);

	pointer_file u_pointer_file (
		.clk_sys     (clk_sys),
		.HALTRST     (HALTRST),
		.zp          (zp),
		.d_in        (d_in),
		.step        (step),
		.sample      (sample),
		.next_byte   (next_byte),
		.start       (start),
		.kind        (kind),
		.ab          (ab),
		.aben        (aben),
		.offset_zero (offset_zero),
		.width_last  (width_last),
		.in_hole     (in_hole),
		.dli_flag    (dli_flag)
	);

	line_out u_line_out (
		.clk_sys    (clk_sys),
		.HALTRST    (HALTRST),
		.d_in       (d_in),
		.sample     (sample),
		.pal_load   (pal_load),
		.wm_load    (wm_load),
		.hpos_load  (hpos_load),
		.gfx_load   (gfx_load),
		.dli_fire   (dli_fire),
		.lr_data    (lr_data),
		.latch_byte (latch_byte),
		.latch_hpos (latch_hpos),
		.wm         (wm),
		.nmi_n      (nmi_n),
		.pal        (pal)
	);

endmodule

// ==== verilog/line_out.sv ====
//////////////////////////////////////////////////
// Line-RAM output stage
// Registers fetched bytes with their strobes,
// palette and write mode, stretches DLI to nmi_n
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "maria_consts.svh"

module line_out (
	input  logic                     clk_sys,
	input  logic                     HALTRST,
	input  logic [7:0]               d_in,
	input  logic                     sample,
	input  logic                     pal_load,
	input  logic                     wm_load,
	input  logic                     hpos_load,
	input  logic                     gfx_load,
	input  logic                     dli_fire,
	output logic [7:0]               lr_data,
	output logic                     latch_byte,
	output logic                     latch_hpos,
	output logic                     wm,
	output logic                     nmi_n,
	output logic [`MARIA_PAL_W-1:0]  pal
);

	localparam int NMI_W = $clog2(`MARIA_NMI_CYCLES + 1);

	maria_list_pkg::hdr_byte_u hdr;
	logic [NMI_W-1:0]          nmi_cnt; // Low cycles left

	assign hdr   = d_in;
	assign nmi_n = nmi_cnt == '0;

	// Data for the strobe, every sampled byte
	always_ff @(posedge clk_sys) begin
		if (sample)
			lr_data <= d_in;
	end

	always_ff @(posedge clk_sys) begin
		if (HALTRST) begin
			latch_byte <= 1'b0;
			latch_hpos <= 1'b0;
			pal        <= '0;
			wm         <= 1'b0;
			nmi_cnt    <= '0;
		end else begin
			latch_byte <= sample && gfx_load;
			latch_hpos <= sample && hpos_load;
			if (sample && pal_load)
				pal <= hdr.pw.pal;
			if (sample && wm_load)
				wm <= hdr.mode.wm; // Kept across short headers
			if (dli_fire)
				nmi_cnt <= NMI_W'(`MARIA_NMI_CYCLES);
			else if (nmi_cnt != '0)
				nmi_cnt <= nmi_cnt - 1'b1;
		end
	end

	// Position and graphics never share a slot
	a_one_strobe: assert property (@(posedge clk_sys) disable iff (HALTRST)
		!(hpos_load && gfx_load));

endmodule

// ==== verilog/pointer_file.sv ====
//////////////////////////////////////////////////
// DMA pointer registers
// Zone, list and graphics pointers, address
// generation and holey-DMA detection
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "maria_consts.svh"

module pointer_file (
	input  logic                          clk_sys,
	input  logic                          HALTRST,
	input  logic [`MARIA_ADDR_W-1:0]      zp,
	input  logic [7:0]                    d_in,
	input  dma_seq_pkg::dma_step_e        step,
	input  logic                          sample,
	input  logic                          next_byte,
	input  logic                          start,
	input  dma_seq_pkg::dma_kind_e        kind,
	output logic [`MARIA_ADDR_W-1:0]      ab,
	output logic                          aben,
	output logic                          offset_zero,
	output logic                          width_last,
	output logic                          in_hole,
	output logic                          dli_flag
);

	logic [`MARIA_ADDR_W-1:0]   zone_ptr; // Next DLL byte
	logic [`MARIA_ADDR_W-1:0]   dl_base;  // Start of current zone's list
	logic [`MARIA_ADDR_W-1:0]   dl_ptr;   // Next header byte
	logic [`MARIA_ADDR_W-1:0]   gfx_ptr;
	logic [`MARIA_ADDR_W-1:0]   gfx_addr;
	logic [`MARIA_ADDR_W-1:0]   sel_addr;
	logic [`MARIA_OFFSET_W-1:0] offset;
	logic [`MARIA_WIDTH_W-1:0]  width;    // Counts up to all ones
	logic                       holey16;
	logic                       holey8;
	logic                       list_end;

	assign list_end    = (d_in & `MARIA_END_MASK) == 8'h00;
	assign gfx_addr    = gfx_ptr + {offset, 8'h00}; // Offset into high byte
	assign offset_zero = offset == '0;
	assign width_last  = &width;
	assign in_hole     = gfx_addr[15] &&
		((holey16 && gfx_addr[12]) || (holey8 && gfx_addr[11]));

	always_comb begin
		case (step)
			dma_seq_pkg::step_dll0,
			dma_seq_pkg::step_dll1,
			dma_seq_pkg::step_dll2: sel_addr = zone_ptr;
			dma_seq_pkg::step_gfx:  sel_addr = gfx_addr;
			dma_seq_pkg::step_idle: sel_addr = '0; // Quiet bus between slots
			default:                sel_addr = dl_ptr; // Header bytes
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (HALTRST) begin
			ab       <= '0;
			aben     <= 1'b0;
			zone_ptr <= '0;
			dl_base  <= '0;
			dl_ptr   <= '0;
			gfx_ptr  <= '0;
			offset   <= '0;
			width    <= '0;
			holey16  <= 1'b0;
			holey8   <= 1'b0;
			dli_flag <= 1'b0;
		end else begin
			ab   <= sel_addr; // One cycle behind step
			aben <= (step != dma_seq_pkg::step_idle) && !sample; // Low between slots
			if (start && kind == dma_seq_pkg::kind_zone)
				zone_ptr <= zp;
			else if (start)
				dl_ptr <= dl_base; // Every line rewalks the list
			if (sample) begin
				case (step)
					dma_seq_pkg::step_dll0: begin
						dli_flag <= d_in[7];
						holey16  <= d_in[6];
						holey8   <= d_in[5];
						offset   <= d_in[`MARIA_OFFSET_W-1:0];
						zone_ptr <= zone_ptr + 1'b1;
					end
					dma_seq_pkg::step_dll1: begin
						dl_base[15:8] <= d_in;
						zone_ptr      <= zone_ptr + 1'b1;
					end
					dma_seq_pkg::step_dll2: begin
						dl_base[7:0] <= d_in;
						zone_ptr     <= zone_ptr + 1'b1;
					end
					dma_seq_pkg::step_hdr0: begin
						gfx_ptr[7:0] <= d_in;
						dl_ptr       <= dl_ptr + 1'b1;
					end
					dma_seq_pkg::step_hdr1: begin
						width  <= d_in[`MARIA_WIDTH_W-1:0]; // Long header overwrites later
						dl_ptr <= dl_ptr + 1'b1;
						if (list_end && !offset_zero)
							offset <= offset - 1'b1; // Line done but zone continues
					end
					dma_seq_pkg::step_hdr2: begin
						gfx_ptr[15:8] <= d_in;
						dl_ptr        <= dl_ptr + 1'b1;
					end
					dma_seq_pkg::step_hdr3: begin
						width  <= d_in[`MARIA_WIDTH_W-1:0];
						dl_ptr <= dl_ptr + 1'b1;
					end
					dma_seq_pkg::step_hdr4: dl_ptr <= dl_ptr + 1'b1;
					default: ;
				endcase
			end
			if (next_byte) begin
				gfx_ptr <= gfx_ptr + 1'b1;
				width   <= width + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/dma_sequencer.sv ====
//////////////////////////////////////////////////
// DMA sequencer
// Walks the DLL entry, the header list and the
// graphics bytes of each object, one slot per byte
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "maria_consts.svh"

module dma_sequencer (
	input  logic                   clk_sys,
	input  logic                   HALTRST,
	input  logic                   start,
	input  dma_seq_pkg::dma_kind_e kind,
	input  logic [7:0]             d_in,
	input  logic                   offset_zero,
	input  logic                   width_last,
	input  logic                   in_hole,
	input  logic                   dli_flag,
	output dma_seq_pkg::dma_step_e step,
	output logic                   sample,
	output logic                   next_byte,
	output logic                   pal_load,
	output logic                   wm_load,
	output logic                   hpos_load,
	output logic                   gfx_load,
	output logic                   dli_fire,
	output logic                   dma_done
);

	maria_list_pkg::hdr_byte_u hdr;
	dma_seq_pkg::dma_step_e    step_nxt;
	logic [1:0]                cnt;      // Cycle within slot
	logic                      gap;      // Idle cycle between objects
	logic                      long_q;   // Current header is five bytes
	logic                      slot_end;
	logic                      list_end;
	logic                      long_now;
	logic                      obj_end;
	logic                      is_hdr1;

	// Header byte 1 seen both ways
	assign hdr      = d_in;
	assign list_end = (d_in & `MARIA_END_MASK) == 8'h00;
	assign long_now = hdr.mode.long_hdr && (hdr.pw.width == '0);
	assign is_hdr1  = step == dma_seq_pkg::step_hdr1;
	assign obj_end  = in_hole || width_last; // Hole cuts the object short

	// Graphics reads are the slow ones
	assign slot_end = (step == dma_seq_pkg::step_gfx) ?
		(cnt == 2'(`MARIA_ROM_SLOT - 1)) : (cnt == 2'(`MARIA_RAM_SLOT - 1));
	assign sample   = (step != dma_seq_pkg::step_idle) && slot_end;

	always_comb begin
		step_nxt = dma_seq_pkg::step_idle;
		case (step)
			dma_seq_pkg::step_dll0: step_nxt = dma_seq_pkg::step_dll1;
			dma_seq_pkg::step_dll1: step_nxt = dma_seq_pkg::step_dll2;
			dma_seq_pkg::step_hdr0: step_nxt = dma_seq_pkg::step_hdr1;
			dma_seq_pkg::step_hdr1: begin
				if (!list_end)
					step_nxt = dma_seq_pkg::step_hdr2;
				else if (offset_zero)
					step_nxt = dma_seq_pkg::step_dll0; // Zone done, fetch next entry
			end
			dma_seq_pkg::step_hdr2: begin
				step_nxt = long_q ? dma_seq_pkg::step_hdr3 : dma_seq_pkg::step_hdr4;
			end
			dma_seq_pkg::step_hdr3: step_nxt = dma_seq_pkg::step_hdr4;
			dma_seq_pkg::step_hdr4: step_nxt = dma_seq_pkg::step_gfx;
			dma_seq_pkg::step_gfx: begin
				if (!obj_end)
					step_nxt = dma_seq_pkg::step_gfx; // Next byte, new slot
			end
			default: ; // dll2 and idle stop here
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (HALTRST) begin
			step   <= dma_seq_pkg::step_idle;
			cnt    <= '0;
			gap    <= 1'b0;
			long_q <= 1'b0;
		end else begin
			if (gap) begin
				gap  <= 1'b0;
				step <= dma_seq_pkg::step_hdr0; // Resume the header walk
				cnt  <= '0;
			end else if (start) begin
				step <= (kind == dma_seq_pkg::kind_zone) ?
					dma_seq_pkg::step_dll0 : dma_seq_pkg::step_hdr0;
				cnt  <= '0;
			end else if (sample) begin
				step <= step_nxt;
				cnt  <= '0;
				gap  <= (step == dma_seq_pkg::step_gfx) && obj_end;
			end else if (step != dma_seq_pkg::step_idle) begin
				cnt <= cnt + 2'd1;
			end
			if (sample && is_hdr1)
				long_q <= long_now;
		end
	end

	// Strobes, qualified by sample downstream
	assign next_byte = sample && (step == dma_seq_pkg::step_gfx);
	assign pal_load  = (step == dma_seq_pkg::step_hdr3) ||
		(is_hdr1 && !list_end && !long_now); // Short header carries palette here
	assign wm_load   = is_hdr1 && long_now;
	assign hpos_load = step == dma_seq_pkg::step_hdr4;
	assign gfx_load  = (step == dma_seq_pkg::step_gfx) && !in_hole; // Holes write nothing

	// Old zone's DLI bit, before dll0 reloads it
	assign dli_fire = sample && is_hdr1 && list_end && offset_zero && dli_flag;
	assign dma_done = sample && ((step == dma_seq_pkg::step_dll2) ||
		(is_hdr1 && list_end && !offset_zero));

	// Every slot is at least two cycles long
	a_sample_step: assert property (@(posedge clk_sys) disable iff (HALTRST)
		sample |-> $past(step) != dma_seq_pkg::step_idle);

endmodule

// ==== verilog/halt_ctrl.sv ====
//////////////////////////////////////////////////
// DMA start control
// Turns blank pulses into zone or line starts
// and holds halt until the sequencer is done
//////////////////////////////////////////////////

`timescale 1ns/1ps

module halt_ctrl (
	input  logic                   clk_sys,
	input  logic                   HALTRST,
	input  logic                   vbe,
	input  logic                   hbs,
	input  logic                   vblank,
	input  logic                   dma_en,
	input  logic                   dma_done,
	output logic                   start,
	output dma_seq_pkg::dma_kind_e kind,
	output logic                   halt
);

	logic vbe_ok;
	logic hbs_ok;

	// Triggers only while enabled and idle
	assign vbe_ok = vbe && dma_en && !halt;
	assign hbs_ok = hbs && !vblank && dma_en && !halt; // No line DMA in vblank

	always_ff @(posedge clk_sys) begin
		if (HALTRST) begin
			start <= 1'b0;
			kind  <= dma_seq_pkg::kind_zone;
			halt  <= 1'b0;
		end else begin
			start <= vbe_ok || hbs_ok;
			if (vbe_ok)
				kind <= dma_seq_pkg::kind_zone; // vbe wins a tie
			else if (hbs_ok)
				kind <= dma_seq_pkg::kind_line;
			if (vbe_ok || hbs_ok)
				halt <= 1'b1;
			else if (dma_done)
				halt <= 1'b0; // Falls one cycle after done
		end
	end

	// Sequencer finishes only inside a halt window it did not just open
	a_done_in_halt: assert property (@(posedge clk_sys) disable iff (HALTRST)
		dma_done |-> (halt && !start));

endmodule

// ==== verilog/maria_list_pkg.sv ====
//////////////////////////////////////////////////
// Display-list byte layouts
// DLL entry byte 0 and header byte views
//////////////////////////////////////////////////

`include "maria_consts.svh"

package maria_list_pkg;

	// DLL entry byte 0, bytes 1 and 2 hold the list address
	typedef struct packed {
		logic                         dli;     // Raise DLI at zone end
		logic                         holey16; // 4K holes on A12
		logic                         holey8;  // 2K holes on A11
		logic                         spare;
		logic [`MARIA_OFFSET_W-1:0]   offset;  // Lines left in zone
	} dll_byte0_t;

	// Palette and width view
	typedef struct packed {
		logic [`MARIA_PAL_W-1:0]      pal;
		logic [`MARIA_WIDTH_W-1:0]    width;   // Bytes fetched is 32 - width
	} hdr_pw_t;

	// Mode view, only when width is zero and the long marker is set
	typedef struct packed {
		logic                         wm;       // Write mode
		logic                         long_hdr; // Five-byte header marker
		logic                         indirect; // Ignored here
		logic [4:0]                   zero;
	} hdr_mode_t;

	// Header byte 1 is one of the two depending on its own bits
	typedef union packed {
		hdr_pw_t   pw;
		hdr_mode_t mode;
	} hdr_byte_u;

endpackage

// ==== verilog/dma_seq_pkg.sv ====
//////////////////////////////////////////////////
// DMA sequencer step and request kinds
//////////////////////////////////////////////////

package dma_seq_pkg;

	// One step per byte read, graphics shares one step
	typedef enum logic [3:0] {
		step_idle,
		step_dll0, // Flags and offset
		step_dll1, // List address high
		step_dll2, // List address low
		step_hdr0, // Graphics address low
		step_hdr1, // Palette/width or mode
		step_hdr2, // Graphics address high
		step_hdr3, // Palette/width of long header
		step_hdr4, // Horizontal position
		step_gfx
	} dma_step_e;

	// Zone fetch after vblank, line fetch on hblank
	typedef enum logic [0:0] {
		kind_zone,
		kind_line
	} dma_kind_e;

endpackage

// ==== verilog/maria_consts.svh ====
//////////////////////////////////////////////////
// Display-list DMA constants
// Bus widths, slot lengths and list-end masks
//////////////////////////////////////////////////

`ifndef MARIA_CONSTS_SVH
`define MARIA_CONSTS_SVH

// Bus and field widths
`define MARIA_ADDR_W 16
`define MARIA_OFFSET_W 4 // Zone offset, added to high address byte
`define MARIA_WIDTH_W 5
`define MARIA_PAL_W 3

// Read slot lengths in clk_sys cycles
`define MARIA_RAM_SLOT 2 // DLL and header bytes
`define MARIA_ROM_SLOT 3 // Graphics bytes

// Header byte 1 ANDed with this is zero at end of list
`define MARIA_END_MASK 8'h5F

`define MARIA_NMI_CYCLES 4 // Low time of nmi_n per DLI

`endif
